/* sdramPkg.sv */
package sdramPkg;

    // ============================================================
    // Widths
    // ============================================================
    localparam int DATA_W     = 16;    // SDRAM data word
    localparam int ADDR_W     = 22;    // Linear word address
    localparam int LEN_W      = 8;     // Burst length field
    localparam int FIFO_DEPTH = 256;   // Entries per client FIFO
    localparam int LEVEL_W    = 9;     // Fill level, 0 to FIFO_DEPTH

    // Address split, bank on top
    localparam int COL_W  = 8;
    localparam int ROW_W  = 12;
    localparam int BANK_W = 2;

    // ============================================================
    // Timing in CLK cycles
    // ============================================================
    localparam int CAS_LATENCY = 3;    // READ command to first word
    localparam int T_RCD       = 3;    // ACTIVE to READ or WRITE

    // Decoded view of a word address
    typedef struct packed {
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
    } sdramAddrFields_s;

    // Same word read raw or as bank, row and column
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        sdramAddrFields_s  f;
    } sdramAddr_u;

    // Command codes as {rasN, casN, weN}
    typedef enum logic [2:0] {
        NOP       = 3'b111,
        ACTIVE    = 3'b011,
        READ      = 3'b101,
        WRITE     = 3'b100,
        PRECHARGE = 3'b010
    } sdramCmd_e;

endpackage

/* portBus.sv */
`timescale 1ns/100ps

// One client port talking to the arbiter
interface portBus;
    import sdramPkg::*;

    logic              req;      // Burst wanted, held until done
    logic [ADDR_W-1:0] addr;     // Burst start, stable under req
    logic [LEN_W-1:0]  length;   // Words in the burst
    logic              done;     // End of this port's burst
    logic              take;     // Pop the write FIFO head
    logic [DATA_W-1:0] wrWord;   // Write FIFO head word
    logic              put;      // Push rdWord into the read FIFO
    logic [DATA_W-1:0] rdWord;   // Word fetched from SDRAM

    // Port side
    modport client (
        output req, addr, length, wrWord,
        input  done, take, put, rdWord
    );

    // Arbiter side
    modport arbiter (
        input  req, addr, length, wrWord,
        output done, take, put, rdWord
    );

endinterface

/* writePort.sv */
`timescale 1ns/100ps

module writePort (
    input  logic                        CLK,
    input  logic                        RESET_N,
    input  logic [sdramPkg::DATA_W-1:0] wrData,
    input  logic                        wrStrobe,
    input  logic                        wrLoad,
    input  logic [sdramPkg::ADDR_W-1:0] wrStart,
    input  logic [sdramPkg::ADDR_W-1:0] wrMaxAddr,
    input  logic [sdramPkg::LEN_W-1:0]  wrLength,
    output logic                        wrFull,
    portBus.client                      bus
);
    import sdramPkg::*;

    logic [DATA_W-1:0]  mem [FIFO_DEPTH];
    logic [LEVEL_W-2:0] headPtr;      // Next word to SDRAM
    logic [LEVEL_W-2:0] tailPtr;      // Next free slot
    logic [LEVEL_W-1:0] level;
    logic               push;
    logic               pop;
    logic [ADDR_W-1:0]  startReg;
    logic [ADDR_W-1:0]  maxReg;
    logic [LEN_W-1:0]   lenReg;
    logic [ADDR_W-1:0]  curAddr;      // Rolling burst address
    logic               burstReady;

    assign wrFull     = (level == LEVEL_W'(FIFO_DEPTH));
    assign push       = wrStrobe && !wrFull;   // Pushes past full are dropped
    assign pop        = bus.take;
    assign bus.wrWord = mem[headPtr];          // Show-ahead head
    assign bus.addr   = curAddr;
    assign bus.length = lenReg;

    // A whole burst buffered
    assign burstReady = (lenReg != '0) && (level >= LEVEL_W'(lenReg));

    // ============================================================
    // FIFO
    // ============================================================
    always_ff @(posedge CLK)
    begin
        if (push)
            mem[tailPtr] <= wrData;
    end

    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            headPtr <= '0;
            tailPtr <= '0;
            level   <= '0;
        end
        else if (wrLoad)
        begin
            headPtr <= '0;    // Flush
            tailPtr <= '0;
            level   <= '0;
        end
        else
        begin
            if (push)
                tailPtr <= tailPtr + 1'b1;
            if (pop)
                headPtr <= headPtr + 1'b1;
            level <= level + LEVEL_W'(push) - LEVEL_W'(pop);
        end
    end

    // ============================================================
    // Address roll and burst request
    // ============================================================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            startReg <= '0;
            maxReg   <= '0;
            lenReg   <= '0;    // Zero length keeps the port quiet
            curAddr  <= '0;
            bus.req  <= 1'b0;
        end
        else if (wrLoad)
        begin
            startReg <= wrStart;
            maxReg   <= wrMaxAddr;
            lenReg   <= wrLength;
            curAddr  <= wrStart;
            bus.req  <= 1'b0;
        end
        else if (bus.done)
        begin
            bus.req <= 1'b0;
            if (curAddr < maxReg - ADDR_W'(lenReg))
                curAddr <= curAddr + ADDR_W'(lenReg);
            else
                curAddr <= startReg;    // Wrap
        end
        else if (burstReady)
            bus.req <= 1'b1;
    end

endmodule

/* readPort.sv */
`timescale 1ns/100ps

module readPort (
    input  logic                        CLK,
    input  logic                        RESET_N,
    output logic [sdramPkg::DATA_W-1:0] rdData,
    output logic                        rdValid,
    input  logic                        rdStrobe,
    input  logic                        rdLoad,
    input  logic [sdramPkg::ADDR_W-1:0] rdStart,
    input  logic [sdramPkg::ADDR_W-1:0] rdMaxAddr,
    input  logic [sdramPkg::LEN_W-1:0]  rdLength,
    portBus.client                      bus
);
    import sdramPkg::*;

    logic [DATA_W-1:0]  mem [FIFO_DEPTH];
    logic [LEVEL_W-2:0] headPtr;      // Next word to the outside
    logic [LEVEL_W-2:0] tailPtr;      // Next slot for SDRAM data
    logic [LEVEL_W-1:0] level;
    logic               push;
    logic               pop;
    logic [ADDR_W-1:0]  startReg;
    logic [ADDR_W-1:0]  maxReg;
    logic [LEN_W-1:0]   lenReg;
    logic [ADDR_W-1:0]  curAddr;      // Rolling prefetch address
    logic               roomReady;

    assign rdData     = mem[headPtr];
    assign rdValid    = (level != '0);
    assign push       = bus.put;
    assign pop        = rdStrobe && rdValid;   // Strobe on empty ignored
    assign bus.wrWord = '0;                    // No write data from here
    assign bus.addr   = curAddr;
    assign bus.length = lenReg;

    // Space for one more burst
    assign roomReady = (lenReg != '0)
                    && (level < LEVEL_W'(FIFO_DEPTH) - LEVEL_W'(lenReg));

    // ============================================================
    // FIFO
    // ============================================================
    always_ff @(posedge CLK)
    begin
        if (push)
            mem[tailPtr] <= bus.rdWord;
    end

    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            headPtr <= '0;
            tailPtr <= '0;
            level   <= '0;
        end
        else if (rdLoad)
        begin
            headPtr <= '0;
            tailPtr <= '0;
            level   <= '0;
        end
        else
        begin
            if (push)
                tailPtr <= tailPtr + 1'b1;
            if (pop)
                headPtr <= headPtr + 1'b1;
            level <= level + LEVEL_W'(push) - LEVEL_W'(pop);
        end
    end

    // ============================================================
    // Address roll and prefetch request
    // ============================================================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            startReg <= '0;
            maxReg   <= '0;
            lenReg   <= '0;
            curAddr  <= '0;
            bus.req  <= 1'b0;
        end
        else if (rdLoad)
        begin
            startReg <= rdStart;
            maxReg   <= rdMaxAddr;
            lenReg   <= rdLength;
            curAddr  <= rdStart;
            bus.req  <= 1'b0;    // Held low in the load cycle
        end
        else if (bus.done)
        begin
            bus.req <= 1'b0;
            if (curAddr < maxReg - ADDR_W'(lenReg))
                curAddr <= curAddr + ADDR_W'(lenReg);
            else
                curAddr <= startReg;
        end
        else if (roomReady)
            bus.req <= 1'b1;
    end

endmodule

/* portArbiter.sv */
`timescale 1ns/100ps

module portArbiter (
    input  logic                        CLK,
    input  logic                        RESET_N,
    portBus.arbiter                     wrBus,
    portBus.arbiter                     rdBus,
    output logic                        start,
    output logic                        write,
    output logic [sdramPkg::ADDR_W-1:0] addr,
    output logic [sdramPkg::LEN_W-1:0]  length,
    input  logic                        done,
    input  logic                        take,
    input  logic                        put,
    output logic [sdramPkg::DATA_W-1:0] wrWord,
    input  logic [sdramPkg::DATA_W-1:0] rdWord
);

    logic busy;       // Engine owned by a port
    logic grantWr;    // Write port holds the grant

    assign write = grantWr;

    // Strobes go to the owner only
    assign wrBus.take   = take & grantWr;
    assign rdBus.take   = take & ~grantWr;
    assign wrBus.done   = done & grantWr;
    assign rdBus.done   = done & ~grantWr;
    assign rdBus.put    = put & ~grantWr;
    assign rdBus.rdWord = rdWord;
    assign wrBus.put    = 1'b0;    // Write side never receives data
    assign wrBus.rdWord = '0;
    assign wrWord       = wrBus.wrWord;

    // Writes first, then reads
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            busy    <= 1'b0;
            start   <= 1'b0;
            grantWr <= 1'b0;
        end
        else
        begin
            start <= 1'b0;    // Single-cycle pulse
            if (!busy)
            begin
                if (wrBus.req || rdBus.req)
                begin
                    busy    <= 1'b1;
                    start   <= 1'b1;
                    grantWr <= wrBus.req;
                end
            end
            else if (done)
                busy <= 1'b0;
        end
    end

    // Latched burst parameters
    always_ff @(posedge CLK)
    begin
        if (!busy && wrBus.req)
        begin
            addr   <= wrBus.addr;
            length <= wrBus.length;
        end
        else if (!busy && rdBus.req)
        begin
            addr   <= rdBus.addr;
            length <= rdBus.length;
        end
    end

endmodule

/* burstEngine.sv */
`timescale 1ns/100ps

module burstEngine (
    input  logic                          CLK,
    input  logic                          RESET_N,
    input  logic                          start,
    input  logic                          write,
    input  logic [sdramPkg::ADDR_W-1:0]   addr,
    input  logic [sdramPkg::LEN_W-1:0]    length,
    output logic                          done,
    output logic                          take,
    output logic                          put,
    input  logic [sdramPkg::DATA_W-1:0]   wrWord,
    output logic [sdramPkg::DATA_W-1:0]   rdWord,
    output logic [sdramPkg::ROW_W-1:0]    sa,
    output logic [sdramPkg::BANK_W-1:0]   ba,
    output logic                          rasN,
    output logic                          casN,
    output logic                          weN,
    output logic [sdramPkg::DATA_W/8-1:0] dqm,
    output logic [sdramPkg::DATA_W-1:0]   dqOut,
    output logic                          dqOe,
    input  logic [sdramPkg::DATA_W-1:0]   dqIn
);
    import sdramPkg::*;

    sdramAddr_u       target;       // addr seen raw and split
    sdramCmd_e        cmd;
    logic             busy;
    logic [LEN_W+1:0] step;         // Cycles since start
    logic [LEN_W+1:0] accessStep;   // Step that loads READ or WRITE
    logic [LEN_W+1:0] dataLo;       // Last step before data cycles
    logic [LEN_W+1:0] lastData;     // Last data cycle
    logic             dataNext;     // Next cycle carries data
    logic             sampleNow;    // dqIn valid this cycle

    assign target.raw = addr;
    assign {rasN, casN, weN} = cmd;

    // ============================================================
    // Burst schedule
    // ============================================================
    assign accessStep = (LEN_W+2)'(T_RCD);
    assign dataLo     = write ? accessStep : (LEN_W+2)'(T_RCD + CAS_LATENCY);
    assign lastData   = dataLo + (LEN_W+2)'(length);
    assign dataNext   = busy && (step >= dataLo) && (step < lastData);
    assign sampleNow  = busy && !write && (step > dataLo) && (step <= lastData);
    assign take       = dataNext && write;    // One cycle ahead of the word

    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            busy <= 1'b0;
            step <= '0;
            cmd  <= NOP;
            dqm  <= '1;
            dqOe <= 1'b0;
            put  <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            cmd  <= NOP;                     // Default every cycle
            dqm  <= dataNext ? '0 : '1;      // Masked outside data
            dqOe <= take;
            put  <= sampleNow;               // Follows the sample
            done <= 1'b0;
            if (!busy)
            begin
                if (start)
                begin
                    busy <= 1'b1;
                    step <= (LEN_W+2)'(1);
                    cmd  <= ACTIVE;
                end
            end
            else
            begin
                step <= step + 1'b1;
                if (step == accessStep)
                    cmd <= write ? WRITE : READ;    // Full-page burst
                if (step == lastData)
                    cmd <= PRECHARGE;               // Ends the burst
                if (step == lastData + 1'b1)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // ============================================================
    // Address and data pins
    // ============================================================
    always_ff @(posedge CLK)
    begin
        if (!busy && start)
        begin
            ba <= target.f.bank;
            sa <= target.f.row;
        end
        else if (busy && step == accessStep)
            sa <= {{(ROW_W-COL_W){1'b0}}, target.f.col};
        else if (busy && step == lastData)
            sa <= 12'h400;                  // A10 high, all banks
        if (take)
            dqOut <= wrWord;
        if (sampleNow)
            rdWord <= dqIn;
    end

endmodule

/* sdramBurstCtrl.sv */
`timescale 1ns/100ps

module sdramBurstCtrl (
    input  logic                          CLK,
    input  logic                          RESET_N,
    // Write client
    input  logic [sdramPkg::DATA_W-1:0]   wrData,
    input  logic                          wrStrobe,
    input  logic                          wrLoad,
    input  logic [sdramPkg::ADDR_W-1:0]   wrStart,
    input  logic [sdramPkg::ADDR_W-1:0]   wrMaxAddr,
    input  logic [sdramPkg::LEN_W-1:0]    wrLength,
    output logic                          wrFull,
    // Read client
    output logic [sdramPkg::DATA_W-1:0]   rdData,
    output logic                          rdValid,
    input  logic                          rdStrobe,
    input  logic                          rdLoad,
    input  logic [sdramPkg::ADDR_W-1:0]   rdStart,
    input  logic [sdramPkg::ADDR_W-1:0]   rdMaxAddr,
    input  logic [sdramPkg::LEN_W-1:0]    rdLength,
    // SDRAM pins
    output logic [sdramPkg::ROW_W-1:0]    sa,
    output logic [sdramPkg::BANK_W-1:0]   ba,
    output logic                          rasN,
    output logic                          casN,
    output logic                          weN,
    output logic [sdramPkg::DATA_W/8-1:0] dqm,
    output logic [sdramPkg::DATA_W-1:0]   dqOut,
    output logic                          dqOe,
    input  logic [sdramPkg::DATA_W-1:0]   dqIn
);
    import sdramPkg::*;

    logic              engStart;
    logic              engWrite;
    logic [ADDR_W-1:0] engAddr;
    logic [LEN_W-1:0]  engLength;
    logic              engDone;
    logic              engTake;
    logic              engPut;
    logic [DATA_W-1:0] engWrWord;
    logic [DATA_W-1:0] engRdWord;

    portBus wrBus ();
    portBus rdBus ();

    writePort u_writePort (
        .CLK, .RESET_N, .wrData, .wrStrobe, .wrLoad, .wrStart, .wrMaxAddr,
        .wrLength, .wrFull, .bus(wrBus)
    );

    readPort u_readPort (
        .CLK, .RESET_N, .rdData, .rdValid, .rdStrobe, .rdLoad, .rdStart,
        .rdMaxAddr, .rdLength, .bus(rdBus)
    );

    portArbiter u_portArbiter (
        .CLK, .RESET_N, .wrBus(wrBus), .rdBus(rdBus),
        .start(engStart), .write(engWrite), .addr(engAddr), .length(engLength),
        .done(engDone), .take(engTake), .put(engPut),
        .wrWord(engWrWord), .rdWord(engRdWord)
    );

    burstEngine u_burstEngine (
        .CLK, .RESET_N,
        .start(engStart), .write(engWrite), .addr(engAddr), .length(engLength),
        .done(engDone), .take(engTake), .put(engPut),
        .wrWord(engWrWord), .rdWord(engRdWord),
        .sa, .ba, .rasN, .casN, .weN, .dqm, .dqOut, .dqOe, .dqIn
    );

endmodule

/* tbSdramModel.sv */
`timescale 1ns/100ps

module tbSdramModel (
    input  logic                          CLK,
    input  logic [sdramPkg::ROW_W-1:0]    sa,
    input  logic [sdramPkg::BANK_W-1:0]   ba,
    input  logic                          rasN,
    input  logic                          casN,
    input  logic                          weN,
    input  logic [sdramPkg::DATA_W/8-1:0] dqm,
    input  logic [sdramPkg::DATA_W-1:0]   dqOut,
    input  logic                          dqOe,
    output logic [sdramPkg::DATA_W-1:0]   dqIn
);
    import sdramPkg::*;

    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];   // Sparse storage
    logic [ROW_W-1:0]  openRow [1 << BANK_W];      // Row opened per bank
    sdramCmd_e         cmd;
    logic [COL_W-1:0]  wrCol;
    logic [COL_W-1:0]  rdCol;
    logic [BANK_W-1:0] rdBank;
    logic              reading;                    // Read burst running
    int                latWait;                    // Cycles left before data

    assign cmd = sdramCmd_e'({rasN, casN, weN});

    // Linear index from bank, open row and column
    function automatic logic [ADDR_W-1:0] wordIndex(input logic [BANK_W-1:0] b,
                                                    input logic [COL_W-1:0]  c);
        sdramAddr_u loc;
        loc.f.bank = b;
        loc.f.row  = openRow[b];
        loc.f.col  = c;
        return loc.raw;
    endfunction

    initial
    begin
        dqIn    = '0;
        reading = 1'b0;
        latWait = 0;
    end

    // ============================================================
    // Command decode, full-page bursts
    // ============================================================
    always @(posedge CLK)
    begin
        if (reading)
        begin
            if (latWait == 0)
            begin
                dqIn  <= mem.exists(wordIndex(rdBank, rdCol)) ? mem[wordIndex(rdBank, rdCol)]
                                                             : '0;
                rdCol = rdCol + 1'b1;           // Column wraps inside the page
            end
            else
                latWait = latWait - 1;
        end
        case (cmd)
            ACTIVE:    openRow[ba] = sa;
            READ:
            begin
                reading = 1'b1;
                latWait = CAS_LATENCY - 2;      // Word valid CL edges after READ
                rdCol   = sa[COL_W-1:0];
                rdBank  = ba;
            end
            WRITE:     wrCol = sa[COL_W-1:0];  // First word comes with the command
            PRECHARGE: reading = 1'b0;
            default:   ;
        endcase
        if (dqOe && dqm == '0)
        begin
            mem[wordIndex(ba, wrCol)] = dqOut;
            wrCol = wrCol + 1'b1;
        end
    end

endmodule

/* tbSdramBurstCtrl.sv */
`timescale 1ns/100ps

module tbSdramBurstCtrl;
    import sdramPkg::*;

    localparam int TIMEOUT = 4000;                     // Cycles allowed per wait
    localparam logic [ADDR_W-1:0] T3_START = 22'h000100;
    localparam logic [ADDR_W-1:0] T3_MAX   = 22'h000120;   // Fifth burst wraps
    localparam logic [ADDR_W-1:0] T4_START = 22'h25A340;   // Bank 2, row 5A3
    localparam logic [ADDR_W-1:0] T4_MAX   = 22'h25A370;
    localparam logic [ADDR_W-1:0] T5_START = 22'h010000;
    localparam logic [ADDR_W-1:0] T5_MAX   = 22'h010040;

    logic                CLK = 1'b0;
    logic                RESET_N;
    logic [DATA_W-1:0]   wrData;
    logic                wrStrobe;
    logic                wrLoad;
    logic [ADDR_W-1:0]   wrStart;
    logic [ADDR_W-1:0]   wrMaxAddr;
    logic [LEN_W-1:0]    wrLength;
    logic                wrFull;
    logic [DATA_W-1:0]   rdData;
    logic                rdValid;
    logic                rdStrobe = 1'b0;              // Owned by the compare process
    logic                rdLoad;
    logic [ADDR_W-1:0]   rdStart;
    logic [ADDR_W-1:0]   rdMaxAddr;
    logic [LEN_W-1:0]    rdLength;
    logic [ROW_W-1:0]    sa;
    logic [BANK_W-1:0]   ba;
    logic                rasN;
    logic                casN;
    logic                weN;
    logic [DATA_W/8-1:0] dqm;
    logic [DATA_W-1:0]   dqOut;
    logic                dqOe;
    logic [DATA_W-1:0]   dqIn;

    logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];   // Expected SDRAM contents
    logic [ADDR_W-1:0] wrCur;                         // Write roll tracking
    int                wrOff;
    int                wrBursts;
    logic              fullSeen;                      // wrFull met while pushing
    logic [ADDR_W-1:0] rdCur;                         // Read roll tracking
    int                rdOff = 0;
    logic              readOn;
    int                readCount = 0;
    logic              actCheck;                      // ACTIVE address check on
    logic [ADDR_W-1:0] actStart;
    logic [ADDR_W-1:0] actMax;
    logic [LEN_W-1:0]  actLen;
    logic [ADDR_W-1:0] actAddr;
    sdramAddr_u        target;
    sdramCmd_e         pinCmd;
    int                activeCount = 0;
    int                prechargeCount = 0;
    int                writeCount = 0;
    int                errors = 0;
    int                checks = 0;
    int                tests = 0;
    int                testErrors = 0;

    sdramBurstCtrl u_sdramBurstCtrl (.*);
    tbSdramModel   u_sdramModel (.*);

    always #10 CLK = ~CLK;    // 20 ns period

    // Address after cur under the port roll rule
    function automatic logic [ADDR_W-1:0] rollAddr(input logic [ADDR_W-1:0] cur,
                                                   input logic [ADDR_W-1:0] first,
                                                   input logic [ADDR_W-1:0] last,
                                                   input logic [LEN_W-1:0]  len);
        if (cur < last - ADDR_W'(len))
            return cur + ADDR_W'(len);
        return first;    // Wrap
    endfunction

    // Reference word at a linear address
    function automatic logic [DATA_W-1:0] expectedWord(input logic [ADDR_W-1:0] a);
        if (shadow.exists(a))
            return shadow[a];
        return '0;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic abortRun(input string why);
        $display("Error at %0t: %s", $time, why);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic finishTest(input string name);
        tests++;
        $display("Test %0d %s: %s", tests, name, (errors == testErrors) ? "passed" : "failed");
        testErrors = errors;
    endtask

    // ============================================================
    // Port setup and stimulus
    // ============================================================
    task automatic loadWrite(input logic [ADDR_W-1:0] s, input logic [ADDR_W-1:0] m,
                             input logic [LEN_W-1:0] l);
        @(negedge CLK);
        wrStart   = s;
        wrMaxAddr = m;
        wrLength  = l;
        wrLoad    = 1'b1;
        wrCur     = s;
        wrOff     = 0;
        @(negedge CLK);
        wrLoad = 1'b0;
    endtask

    task automatic pushWords(input int n);
        logic [DATA_W-1:0] word;
        int                spin;
        for (int i = 0; i < n; i++)
        begin
            @(negedge CLK);
            wrStrobe = 1'b0;
            spin     = 0;
            while (wrFull)    // Hold off while the FIFO is full
            begin
                fullSeen = 1'b1;
                spin++;
                if (spin > TIMEOUT)
                    abortRun("write FIFO stayed full");
                @(negedge CLK);
            end
            word     = DATA_W'($urandom);
            wrData   = word;
            wrStrobe = 1'b1;
            shadow[wrCur + ADDR_W'(wrOff)] = word;
            wrOff++;
            if (wrOff == int'(wrLength))
            begin
                wrOff = 0;
                wrCur = rollAddr(wrCur, wrStart, wrMaxAddr, wrLength);
                wrBursts++;
            end
        end
        @(negedge CLK);
        wrStrobe = 1'b0;
    endtask

    // Every full burst written and no burst open
    task automatic waitWrites();
        int spin;
        spin = 0;
        while (writeCount < wrBursts || activeCount != prechargeCount)
        begin
            spin++;
            if (spin > TIMEOUT)
                abortRun("write bursts did not reach the SDRAM");
            @(negedge CLK);
        end
    endtask

    task automatic loadRead(input logic [ADDR_W-1:0] s, input logic [ADDR_W-1:0] m,
                            input logic [LEN_W-1:0] l);
        @(negedge CLK);
        rdStart   = s;
        rdMaxAddr = m;
        rdLength  = l;
        rdLoad    = 1'b1;
        @(negedge CLK);
        rdLoad = 1'b0;
        @(negedge CLK);
        readOn = 1'b1;    // Compare process has picked up the new start
    endtask

    task automatic waitReads(input int n);
        int base;
        int spin;
        base = readCount;
        spin = 0;
        while (readCount - base < n)
        begin
            spin++;
            if (spin > TIMEOUT)
                abortRun("read port delivered too few words");
            @(negedge CLK);
        end
    endtask

    // Stop prefetch, let an open burst end, then flush its words
    task automatic quiesceReads();
        int spin;
        @(negedge CLK);
        readOn   = 1'b0;
        rdLength = '0;
        rdLoad   = 1'b1;
        @(negedge CLK);
        rdLoad = 1'b0;
        repeat (2) @(negedge CLK);    // Grant in the load cycle reaches ACTIVE by now
        spin = 0;
        while (activeCount != prechargeCount)
        begin
            spin++;
            if (spin > TIMEOUT)
                abortRun("burst did not end after stopping the read port");
            @(negedge CLK);
        end
        @(negedge CLK);
        rdLoad = 1'b1;
        @(negedge CLK);
        rdLoad = 1'b0;
    endtask

    task automatic armActive(input logic [ADDR_W-1:0] s, input logic [ADDR_W-1:0] m,
                             input logic [LEN_W-1:0] l);
        @(negedge CLK);
        actCheck = 1'b0;
        actStart = s;
        actMax   = m;
        actLen   = l;
        repeat (2) @(negedge CLK);
        actCheck = 1'b1;
    endtask

    // ============================================================
    // Pin monitor and read compare
    // ============================================================
    always @(negedge CLK)
    begin
        pinCmd   = sdramCmd_e'({rasN, casN, weN});
        rdStrobe = 1'b0;
        if (RESET_N)
        begin
            if (pinCmd == ACTIVE)
            begin
                activeCount++;
                if (actCheck)
                begin
                    target.raw = actAddr;
                    checkValue("ba", 32'(ba), 32'(target.f.bank));
                    checkValue("sa", 32'(sa), 32'(target.f.row));
                    actAddr = rollAddr(actAddr, actStart, actMax, actLen);
                end
            end
            if (pinCmd == PRECHARGE)
                prechargeCount++;
            if (pinCmd == WRITE)
                writeCount++;
            if (!actCheck)
                actAddr = actStart;
            if (!readOn)
            begin
                rdCur = rdStart;    // Restart at the loaded address
                rdOff = 0;
            end
            else if (rdValid)
            begin
                checkValue("rdData", 32'(rdData), 32'(expectedWord(rdCur + ADDR_W'(rdOff))));
                rdStrobe = 1'b1;    // Pop on the next rising edge
                readCount++;
                rdOff++;
                if (rdOff == int'(rdLength))
                begin
                    rdOff = 0;
                    rdCur = rollAddr(rdCur, rdStart, rdMaxAddr, rdLength);
                end
            end
        end
    end

    // ============================================================
    // Test sequence
    // ============================================================
    initial
    begin
        RESET_N   = 1'b0;
        wrData    = '0;
        wrStrobe  = 1'b0;
        wrLoad    = 1'b0;
        wrStart   = '0;
        wrMaxAddr = '0;
        wrLength  = '0;
        rdLoad    = 1'b0;
        rdStart   = '0;
        rdMaxAddr = '0;
        rdLength  = '0;     // Read port idle until loaded
        readOn    = 1'b0;
        actCheck  = 1'b0;
        actStart  = '0;
        actMax    = '0;
        actLen    = '0;
        wrCur     = '0;
        wrOff     = 0;
        wrBursts  = 0;
        fullSeen  = 1'b0;
        void'($urandom(32'h27e7_2881));
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        RESET_N = 1'b1;

        @(negedge CLK);
        checkValue("cmd", 32'({rasN, casN, weN}), 32'(NOP));
        checkValue("dqOe", 32'(dqOe), 32'h0);
        checkValue("rdValid", 32'(rdValid), 32'h0);
        checkValue("dqm", 32'(dqm), 32'h3);
        finishTest("reset state");

        loadWrite(22'h000000, 22'h000040, 8'd8);
        pushWords(8);
        waitWrites();
        loadRead(22'h000000, 22'h000008, 8'd8);
        waitReads(16);    // Second pass covers the wrap
        quiesceReads();
        finishTest("single burst");

        loadWrite(T3_START, T3_MAX, 8'd8);
        pushWords(40);
        waitWrites();
        loadRead(T3_START, T3_MAX, 8'd8);
        waitReads(32);
        quiesceReads();
        finishTest("address wrap");

        armActive(T4_START, T4_MAX, 8'd16);
        loadWrite(T4_START, T4_MAX, 8'd16);
        pushWords(48);
        waitWrites();
        armActive(T4_START, T4_MAX, 8'd16);
        loadRead(T4_START, T4_MAX, 8'd16);
        waitReads(48);
        actCheck = 1'b0;
        quiesceReads();
        finishTest("bank and row");

        loadWrite(T5_START, T5_MAX, 8'd8);
        loadRead(T3_START, T3_MAX, 8'd8);
        fork
            pushWords(512);    // Outruns the drain, so the FIFO fills
            waitReads(48);
        join
        waitWrites();
        checkValue("wrFull while pushing", 32'(fullSeen), 32'h1);
        checkValue("wrFull", 32'(wrFull), 32'h0);
        quiesceReads();
        loadRead(T5_START, T5_MAX, 8'd8);
        waitReads(64);
        quiesceReads();
        finishTest("concurrent ports");

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* all.f */
sdramPkg.sv
portBus.sv
writePort.sv
readPort.sv
portArbiter.sv
burstEngine.sv
sdramBurstCtrl.sv
tbSdramModel.sv
tbSdramBurstCtrl.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the SDRAM burst controller testbench with Verilator
set -e -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tbSdramBurstCtrl -f all.f -o simSdram
./obj_dir/simSdram | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation finished without failures"
